//--- vlog.f
fb_ctrl_pkg.sv
fb_frame_pkg.sv
err_demod.sv
feedback_step_gen.sv
phase_ramp.sv
fb_loop_top.sv
tb_fb_loop.sv

//--- tb_fb_loop.sv
/*
  directed testbench for the phase feedback loop top level.
  random sample frames drive the DUT while a frame model tracks the
  expected error integral, step and ramp phase after every frame
*/
`default_nettype none

module tb_fb_loop;
	import fb_ctrl_pkg::*;
	import fb_frame_pkg::*;

	localparam int TIMEOUT = 100;  // cycles allowed per wait

	logic                       i_clk;
	logic                       i_rst_n;
	logic                       i_smp_valid;
	logic signed [SAMPLE_W-1:0] i_smp_data;
	logic                       o_smp_ready;
	logic        [MODE_W-1:0]   i_mode;
	logic        [GAIN_W-1:0]   i_gain_sel;
	logic signed [DATA_W-1:0]   i_const_step;
	logic signed [DATA_W-1:0]   o_step;
	logic        [DATA_W-1:0]   o_phase;

	int seed = 32'h5836;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// model state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic signed [DATA_W-1:0] model_integ;
	logic signed [DATA_W-1:0] model_step;
	logic        [DATA_W-1:0] model_phase;
	logic        [MODE_W-1:0] model_mode;
	logic        [GAIN_W-1:0] model_gain;
	logic signed [DATA_W-1:0] model_const;
	int                       sent_cnt;   // samples the source handed over
	int                       acc_cnt;    // samples the DUT took in
	logic                     wrap_seen;

	fb_loop_top fb_loop_top_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_smp_valid  (i_smp_valid),
		.i_smp_data   (i_smp_data),
		.o_smp_ready  (o_smp_ready),
		.i_mode       (i_mode),
		.i_gain_sel   (i_gain_sel),
		.i_const_step (i_const_step),
		.o_step       (o_step),
		.o_phase      (o_phase)
	);

	always #10 i_clk = ~i_clk;

	// accept pulses from inside the DUT
	always @(negedge i_clk) begin
		if (i_rst_n && fb_loop_top_inst.smp_acc)
			acc_cnt++;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reporting and waits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic report_mismatch(input string what, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		$display("ERR at %0t: %s is %h, expected %h", $time, what, got, exp);
		$display(">>> FAIL");
		$fatal(1, "value check failed");
	endtask

	task automatic report_failure(input string what);
		$display("at %0t: %s", $time, what);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic next_cycle;
		@(posedge i_clk);
		#1;  // drive point after the edge
	endtask

	task automatic wait_ready;
		int t;
		t = 0;
		while (!o_smp_ready) begin
			next_cycle();
			t++;
			if (t > TIMEOUT)
				report_failure("timeout waiting for o_smp_ready");
		end
	endtask

	task automatic wait_step(input logic signed [DATA_W-1:0] exp);
		int t;
		t = 0;
		while (o_step !== exp) begin
			next_cycle();
			t++;
			if (t > TIMEOUT)
				report_failure("timeout waiting for o_step to settle");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic send_sample(input logic signed [SAMPLE_W-1:0] d);
		i_smp_valid = 1'b1;
		i_smp_data  = d;
		wait_ready();
		next_cycle();  // handshake on this edge
		sent_cnt++;
	endtask

	task automatic update_model(input logic signed [DATA_W-1:0] err);
		case (model_mode)
			FB_INTEG: begin
				model_integ = model_integ + err;
				model_step  = model_integ >>> model_gain;
			end
			FB_CONST: model_step = model_const;
			default: begin
				model_integ = '0;
				model_step  = '0;
			end
		endcase
	endtask

	task automatic set_controls(input logic [MODE_W-1:0] mode, input logic [GAIN_W-1:0] gain,
		input logic signed [DATA_W-1:0] cst);
		i_mode       = mode;
		i_gain_sel   = gain;
		i_const_step = cst;
		model_mode   = mode;
		model_gain   = gain;
		model_const  = cst;
		if (mode != FB_INTEG && mode != FB_CONST) begin
			model_integ = '0;
			model_step  = '0;
		end
		wait_step(model_step);
		repeat (2) next_cycle();  // controls registered
		assert (o_step == model_step) else report_mismatch("o_step", o_step, model_step);
	endtask

	// neg forces a negative frame error
	task automatic run_frames(input int n, input bit neg);
		logic signed [SAMPLE_W-1:0] smp;
		logic signed [DATA_W-1:0]   err;
		logic        [DATA_W:0]     wide;
		int                         f;
		int                         i;
		for (f = 0; f < n; f++) begin
			err = '0;
			for (i = 0; i < FRAME_LEN; i++) begin
				smp = $random(seed);
				if (neg)
					smp[SAMPLE_W-1] = (i < HALF_LEN);
				if (i < HALF_LEN)
					err = err + smp;   // +1 half of the square wave
				else
					err = err - smp;
				wide = {1'b0, model_phase} + {1'b0, model_step};
				if (wide[DATA_W])
					wrap_seen = 1'b1;
				model_phase = wide[DATA_W-1:0];
				send_sample(smp);
			end
			assert (!o_smp_ready)
				else report_failure("o_smp_ready stayed high after the last sample of a frame");
			update_model(err);
		end
		i_smp_valid = 1'b0;
		wait_ready();
		assert (o_step == model_step) else report_mismatch("o_step", o_step, model_step);
		assert (o_phase == model_phase) else report_mismatch("o_phase", o_phase, model_phase);
		assert (acc_cnt == sent_cnt) else report_mismatch("sample count", acc_cnt, sent_cnt);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic reset_and_off;
		i_rst_n = 1'b0;
		repeat (16) next_cycle();
		assert (!o_smp_ready) else report_failure("o_smp_ready high during reset");
		assert (o_step == '0) else report_mismatch("o_step", o_step, '0);
		assert (o_phase == '0) else report_mismatch("o_phase", o_phase, '0);
		i_rst_n = 1'b1;
		wait_ready();
		set_controls(FB_OFF, GAIN_DEFAULT, '0);
		run_frames(1, 1'b0);
	endtask

	task automatic integ_default_gain;
		set_controls(FB_INTEG, GAIN_DEFAULT, '0);
		repeat (3) run_frames(1, 1'b0);
		run_frames(2, 1'b1);
		assert (model_integ < 0) else report_failure("stimulus did not reach a negative integral");
	endtask

	task automatic gain_change;
		set_controls(FB_INTEG, 5'd2, '0);
		run_frames(1, 1'b0);
		set_controls(FB_INTEG, 5'd9, '0);
		run_frames(1, 1'b0);
	endtask

	task automatic const_then_off;
		set_controls(FB_CONST, GAIN_DEFAULT, 32'shFFFF_F3A0);
		run_frames(1, 1'b0);
		set_controls(FB_OFF, GAIN_DEFAULT, '0);
		set_controls(FB_INTEG, GAIN_DEFAULT, '0);  // integral restarts at zero
		run_frames(1, 1'b0);
	endtask

	task automatic valid_held;
		run_frames(3, 1'b0);  // back to back, valid never drops
	endtask

	task automatic phase_wrap;
		set_controls(FB_CONST, GAIN_DEFAULT, 32'sh1234_5677);
		wrap_seen = 1'b0;
		run_frames(2, 1'b0);
		assert (wrap_seen) else report_failure("large step did not wrap the phase");
	endtask

	initial begin
		i_clk        = 1'b0;
		i_rst_n      = 1'b0;
		i_smp_valid  = 1'b0;
		i_smp_data   = '0;
		i_mode       = FB_OFF;
		i_gain_sel   = GAIN_DEFAULT;
		i_const_step = '0;
		model_integ  = '0;
		model_step   = '0;
		model_phase  = '0;
		model_mode   = FB_OFF;
		model_gain   = GAIN_DEFAULT;
		model_const  = '0;
		sent_cnt     = 0;
		acc_cnt      = 0;
		wrap_seen    = 1'b0;

		reset_and_off();
		integ_default_gain();
		gain_change();
		const_then_off();
		valid_held();
		phase_wrap();

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- fb_loop_top.sv
/*
  top level of the phase feedback loop back end.
  samples in over valid/ready, step and ramp phase out every cycle
*/
`default_nettype none

module fb_loop_top (
	input  logic                                     i_clk,
	input  logic                                     i_rst_n,
	input  logic                                     i_smp_valid,
	input  logic signed [fb_frame_pkg::SAMPLE_W-1:0] i_smp_data,
	output logic                                     o_smp_ready,
	input  logic        [fb_ctrl_pkg::MODE_W-1:0]    i_mode,
	input  logic        [fb_ctrl_pkg::GAIN_W-1:0]    i_gain_sel,
	input  logic signed [fb_ctrl_pkg::DATA_W-1:0]    i_const_step,
	output logic signed [fb_ctrl_pkg::DATA_W-1:0]    o_step,
	output logic        [fb_ctrl_pkg::DATA_W-1:0]    o_phase
);
	import fb_ctrl_pkg::*;

	logic                     smp_acc;
	logic signed [DATA_W-1:0] err;
	logic                     trig;
	logic                     trig_dly;

	err_demod err_demod_inst (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_smp_valid (i_smp_valid),
		.i_smp_data  (i_smp_data),
		.o_smp_ready (o_smp_ready),
		.o_smp_acc   (smp_acc),
		.o_err       (err),
		.o_trig      (trig),
		.o_trig_dly  (trig_dly)
	);

	feedback_step_gen feedback_step_gen_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_trig       (trig),
		.i_trig_dly   (trig_dly),
		.i_err        (err),
		.i_gain_sel   (i_gain_sel),
		.i_mode       (i_mode),
		.i_const_step (i_const_step),
		.o_step       (o_step)      // also drives the ramp
	);

	phase_ramp phase_ramp_inst (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_smp_acc (smp_acc),
		.i_step    (o_step),
		.o_phase   (o_phase)
	);

endmodule

`default_nettype wire

//--- phase_ramp.sv
/*
  phase ramp accumulator. adds the current step once per accepted
  sample and wraps modulo 2^DATA_W, giving a sawtooth whose slope
  is the feedback value
*/
`default_nettype none

module phase_ramp (
	input  logic                                  i_clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_smp_acc,
	input  logic signed [fb_ctrl_pkg::DATA_W-1:0] i_step,
	output logic        [fb_ctrl_pkg::DATA_W-1:0] o_phase
);
	import fb_ctrl_pkg::*;

	logic [DATA_W-1:0] r_phase;
	logic [DATA_W-1:0] phase_next;

	// two's complement add, so a negative step ramps down
	assign phase_next = r_phase + DATA_W'(i_step);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			r_phase <= '0;
		else if (i_smp_acc)
			r_phase <= phase_next;  // carry out is dropped
	end

	assign o_phase = r_phase;

endmodule

`default_nettype wire

//--- feedback_step_gen.sv
/*
  feedback step generator. INTEG integrates the frame error and scales
  it by an arithmetic right shift, CONST loads an external step and OFF
  holds the step at zero. controls are sampled every cycle
*/
`default_nettype none

module feedback_step_gen (
	input  logic                                  i_clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_trig,
	input  logic                                  i_trig_dly,
	input  logic signed [fb_ctrl_pkg::DATA_W-1:0] i_err,
	input  logic        [fb_ctrl_pkg::GAIN_W-1:0] i_gain_sel,
	input  logic        [fb_ctrl_pkg::MODE_W-1:0] i_mode,
	input  logic signed [fb_ctrl_pkg::DATA_W-1:0] i_const_step,
	output logic signed [fb_ctrl_pkg::DATA_W-1:0] o_step
);
	import fb_ctrl_pkg::*;

	logic signed [DATA_W-1:0] r_err;
	logic signed [DATA_W-1:0] r_const;
	logic        [MODE_W-1:0] r_mode;
	logic        [GAIN_W-1:0] r_gain;
	logic signed [DATA_W-1:0] r_integ;  // running sum of frame errors

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// input registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_mode <= FB_OFF;
			r_gain <= GAIN_DEFAULT;
		end else begin
			r_mode <= i_mode;
			r_gain <= i_gain_sel;
		end
	end

	always_ff @(posedge i_clk) begin
		r_err   <= i_err;         // settled one cycle before trig
		r_const <= i_const_step;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// integrator and step
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_integ <= '0;
			o_step  <= '0;
		end else begin
			case (r_mode)
				FB_INTEG: begin
					if (i_trig)
						r_integ <= r_integ + r_err;
					else if (i_trig_dly)
						o_step <= r_integ >>> r_gain;  // keeps the sign
				end
				FB_CONST: begin
					if (i_trig)
						o_step <= r_const;  // integrator left as it was
				end
				default: begin  // OFF and the reserved code
					r_integ <= '0;
					o_step  <= '0;
				end
			endcase
		end
	end

	// trig_dly comes from the demodulator's trigger chain
	a_dly_after_trig: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_trig_dly |-> $past(i_trig))
		else $error("trig_dly without a preceding trig");

endmodule

`default_nettype wire

//--- err_demod.sv
/*
  square-wave demodulator. accepted samples of the first half of a frame
  are added and those of the second half subtracted. at frame end the sum
  goes to o_err, then trig and trig_dly pulse while input ready is low
*/
`default_nettype none

module err_demod (
	input  logic                                     i_clk,
	input  logic                                     i_rst_n,
	input  logic                                     i_smp_valid,
	input  logic signed [fb_frame_pkg::SAMPLE_W-1:0] i_smp_data,
	output logic                                     o_smp_ready,
	output logic                                     o_smp_acc,
	output logic signed [fb_ctrl_pkg::DATA_W-1:0]    o_err,
	output logic                                     o_trig,
	output logic                                     o_trig_dly
);
	import fb_frame_pkg::*;
	import fb_ctrl_pkg::*;

	logic                     smp_acc;     // sample handshake this cycle
	logic                     frame_last;  // counter sits on last sample
	logic signed [DATA_W-1:0] smp_ext;
	logic signed [DATA_W-1:0] sum_next;
	logic [CNT_W-1:0]         r_cnt;
	logic signed [DATA_W-1:0] r_sum;
	logic                     r_err_vld;   // o_err holds a fresh frame

	assign smp_acc    = i_smp_valid && o_smp_ready;
	assign frame_last = (r_cnt == CNT_W'(FRAME_LEN - 1));
	assign smp_ext    = {{(DATA_W - SAMPLE_W){i_smp_data[SAMPLE_W-1]}}, i_smp_data};

	// square-wave reference is +1 then -1
	assign sum_next = (r_cnt < CNT_W'(HALF_LEN)) ? r_sum + smp_ext : r_sum - smp_ext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame counter, sum, trigger chain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_cnt       <= '0;
			r_sum       <= '0;
			o_smp_ready <= 1'b0;
			o_smp_acc   <= 1'b0;
			r_err_vld   <= 1'b0;
			o_trig      <= 1'b0;
			o_trig_dly  <= 1'b0;
		end else begin
			o_smp_acc  <= smp_acc;
			r_err_vld  <= smp_acc && frame_last;
			o_trig     <= r_err_vld;   // one cycle for the step gen to register o_err
			o_trig_dly <= o_trig;
			// low for the three cycles after the last sample
			o_smp_ready <= !((smp_acc && frame_last) || r_err_vld || o_trig);
			if (smp_acc) begin
				if (frame_last) begin
					r_cnt <= '0;
					r_sum <= '0;   // next frame starts clean
				end else begin
					r_cnt <= r_cnt + 1'b1;
					r_sum <= sum_next;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (smp_acc && frame_last)
			o_err <= sum_next;  // includes the last sample
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_trig_apart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_trig && o_trig_dly))
		else $error("trig and trig_dly high together");

	a_no_acc_in_update: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_trig || o_trig_dly) |-> !smp_acc)
		else $error("sample accepted during step update");

endmodule

`default_nettype wire

//--- fb_frame_pkg.sv
/*
  sample-frame constants for the square-wave demodulator.
  one frame of FRAME_LEN accepted samples gives one error value
*/
`default_nettype none

package fb_frame_pkg;

	localparam int SAMPLE_W  = 16;             // signed detector sample
	localparam int FRAME_LEN = 16;             // samples per frame
	localparam int HALF_LEN  = FRAME_LEN / 2;  // first half adds
	localparam int CNT_W     = $clog2(FRAME_LEN);

	// the sample counter must hold FRAME_LEN - 1
	// and the frame must split evenly into two halves

endpackage

`default_nettype wire

//--- fb_ctrl_pkg.sv
/*
  loop-control constants shared by the feedback step generator,
  the phase ramp and the top level. mode codes, word widths, gain default
*/
`default_nettype none

package fb_ctrl_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// word widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int DATA_W = 32;  // error, step and phase words
	localparam int GAIN_W = 5;   // right shift of 0 to 31
	localparam int MODE_W = 2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// gain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// integrator is divided by 2^gain before it becomes the step
	localparam logic [GAIN_W-1:0] GAIN_DEFAULT = 5'd5;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// feedback modes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [MODE_W-1:0] FB_OFF   = 2'd0;  // step held at zero
	localparam logic [MODE_W-1:0] FB_INTEG = 2'd1;  // integrate and scale
	localparam logic [MODE_W-1:0] FB_CONST = 2'd2;  // external constant step
	// code 3 is reserved and acts like FB_OFF

endpackage

`default_nettype wire
